// ==== decomp_settings.svh ====
//----------------------------------------------------------------------
// decompressor settings
// widths, depths and flow-control thresholds of the datapath
//----------------------------------------------------------------------
`ifndef DECOMP_SETTINGS_SVH
`define DECOMP_SETTINGS_SVH

// bytes per input and output bus word
`define DECOMP_WORD_BYTES 4

// history window of 4096 bytes
`define DECOMP_HIST_AW 12

`define DECOMP_IN_FIFO_DEPTH 16	// words
`define DECOMP_CMD_FIFO_DEPTH 8	// commands

// free entries left when almost-full rises
`define DECOMP_ALMOST_FULL_SLACK 2

// byte-counted file lengths
`define DECOMP_CLEN_W 20
`define DECOMP_DLEN_W 20

`endif

// ==== decomp_pkg.sv ====
//----------------------------------------------------------------------
// decompressor types
// bus words, history addresses and the parser-to-engine command
//----------------------------------------------------------------------
`include "decomp_settings.svh"

package decomp_pkg;

	typedef logic [7:0] byte_t;

	typedef logic [`DECOMP_WORD_BYTES*8-1:0] word_t;	// lane 0 in bits 7:0

	typedef logic [`DECOMP_WORD_BYTES-1:0] bvalid_t;	// one flag per lane

	// address in the window, also used for copy offsets
	typedef logic [`DECOMP_HIST_AW-1:0] hist_addr_t;

	typedef enum logic {
		CMD_LIT  = 1'b0,	// one literal byte in lit
		CMD_COPY = 1'b1	// length bytes from offset back
	} cmd_kind_t;

	typedef struct packed {
		cmd_kind_t  kind;
		byte_t      lit;
		hist_addr_t offset;
		logic [6:0] length;	// 1 to 64
		logic       last_cmd;	// ends the compressed input
	} cmd_t;

endpackage

// ==== sync_fifo.sv ====
//----------------------------------------------------------------------
// synchronous first-word-fall-through FIFO
// generic payload with an almost-full level for upstream throttling
//----------------------------------------------------------------------
`timescale 1ns/1ns
`include "decomp_settings.svh"

module sync_fifo #(
	parameter type payload_t = logic [31:0],
	parameter int  DEPTH     = 16,
	parameter int  AF_SLACK  = `DECOMP_ALMOST_FULL_SLACK
) (
	input  logic     clk,
	input  logic     rst_i,
	input  logic     wr_en_i,
	input  payload_t din_i,
	input  logic     rd_en_i,
	output payload_t dout_o,
	output logic     empty_o,
	output logic     almost_full_o
);
	localparam int PTR_W = $clog2(DEPTH);

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;
	logic do_wr;
	logic do_rd;

	assign do_wr = wr_en_i && (count != DEPTH);	// writes into a full buffer are dropped
	assign do_rd = rd_en_i && (count != '0);

	assign dout_o = mem[rd_ptr];	// head word visible while not empty
	assign empty_o = (count == '0);
	assign almost_full_o = (count >= DEPTH - AF_SLACK);

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= din_i;
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + (do_wr ? 1'b1 : 1'b0) - (do_rd ? 1'b1 : 1'b0);
		end
	end

endmodule

// ==== token_parser.sv ====
//----------------------------------------------------------------------
// token parser
// walks the input words byte by byte and turns tags into commands
//----------------------------------------------------------------------
`timescale 1ns/1ns
`include "decomp_settings.svh"

module token_parser import decomp_pkg::*; (
	input  logic                     clk,
	input  logic                     rst_i,
	input  logic                     start_i,
	input  logic [`DECOMP_CLEN_W-1:0] clen_i,
	input  word_t                    word_i,
	input  logic                     empty_i,
	output logic                     rd_en_o,
	output cmd_t                     cmd_o,
	output logic                     cmd_wr_o,
	input  logic                     cmd_full_i
);
	localparam int LANE_W = $clog2(`DECOMP_WORD_BYTES);
	localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(`DECOMP_WORD_BYTES - 1);

	typedef enum logic [1:0] {
		ST_TAG,
		ST_LIT,
		ST_OFF_LO,
		ST_OFF_HI
	} state_t;

	state_t state;
	logic [LANE_W-1:0] lane;
	logic [`DECOMP_CLEN_W-1:0] clen_r;
	logic [`DECOMP_CLEN_W-1:0] byte_cnt;
	logic [6:0] lit_left;	// literal body bytes still to come
	logic [6:0] copy_len;
	logic [2:0] off_hi;	// tag 01 offset bits 10:8
	logic two_byte;	// tag 10 copy in flight
	byte_t off_lo;
	byte_t cur;
	logic step;
	logic real_byte;
	logic end_byte;

	assign cur = word_i[lane*8 +: 8];
	assign real_byte = (byte_cnt != clen_r);	// else padding past the file end
	assign end_byte = real_byte && (byte_cnt + 1'b1 == clen_r);
	assign step = !empty_i && !cmd_full_i;

	// pop after lane 3, or early once the file's bytes are used up
	assign rd_en_o = step && (lane == LAST_LANE || !real_byte || end_byte);

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state <= ST_TAG;
			lane <= '0;
			byte_cnt <= '0;
			clen_r <= '0;
			cmd_wr_o <= 1'b0;
		end else if (start_i) begin
			state <= ST_TAG;
			lane <= '0;
			byte_cnt <= '0;
			clen_r <= clen_i;
			cmd_wr_o <= 1'b0;
		end else begin
			cmd_wr_o <= 1'b0;
			if (step) begin
				lane <= rd_en_o ? '0 : lane + 1'b1;
				if (real_byte) begin
					byte_cnt <= byte_cnt + 1'b1;
					cmd_o.last_cmd <= end_byte;
					case (state)
						ST_TAG: begin
							case (cur[1:0])
								2'b00: begin
									lit_left <= {1'b0, cur[7:2]} + 7'd1;
									state <= ST_LIT;
								end
								2'b01: begin
									copy_len <= {4'b0, cur[4:2]} + 7'd4;
									off_hi <= cur[7:5];
									two_byte <= 1'b0;
									state <= ST_OFF_LO;
								end
								2'b10: begin
									copy_len <= {1'b0, cur[7:2]} + 7'd1;
									two_byte <= 1'b1;
									state <= ST_OFF_LO;
								end
								default: state <= ST_TAG;	// 4-byte offsets unsupported
							endcase
						end
						ST_LIT: begin
							cmd_o.kind <= CMD_LIT;
							cmd_o.lit <= cur;
							cmd_o.offset <= '0;
							cmd_o.length <= 7'd1;
							cmd_wr_o <= 1'b1;
							lit_left <= lit_left - 7'd1;
							if (lit_left == 7'd1)
								state <= ST_TAG;
						end
						ST_OFF_LO: begin
							if (two_byte) begin
								off_lo <= cur;
								state <= ST_OFF_HI;
							end else begin
								cmd_o.kind <= CMD_COPY;
								cmd_o.lit <= '0;
								cmd_o.offset <= hist_addr_t'({off_hi, cur});
								cmd_o.length <= copy_len;
								cmd_wr_o <= 1'b1;
								state <= ST_TAG;
							end
						end
						ST_OFF_HI: begin
							cmd_o.kind <= CMD_COPY;
							cmd_o.lit <= '0;
							cmd_o.offset <= hist_addr_t'({cur, off_lo});	// low byte came first
							cmd_o.length <= copy_len;
							cmd_wr_o <= 1'b1;
							state <= ST_TAG;
						end
						default: state <= ST_TAG;
					endcase
				end
			end
		end
	end

endmodule

// ==== history_engine.sv ====
//----------------------------------------------------------------------
// history engine
// runs literal and copy commands against the byte history window
//----------------------------------------------------------------------
`timescale 1ns/1ns

module history_engine import decomp_pkg::*; (
	input  logic  clk,
	input  logic  rst_i,
	input  logic  start_i,
	input  cmd_t  cmd_i,
	input  logic  cmd_empty_i,
	output logic  cmd_rd_o,
	output byte_t byte_o,
	output logic  byte_valid_o,
	output logic  byte_last_o,
	input  logic  ready_i
);
	localparam int HIST_DEPTH = 2 ** $bits(hist_addr_t);

	typedef enum logic [1:0] {
		S_IDLE,
		S_READ,	// fetch one byte from the window
		S_WRITE	// write it back and emit it
	} state_t;

	byte_t hist_mem [HIST_DEPTH];
	state_t state;
	hist_addr_t wr_ptr;
	hist_addr_t off_r;
	logic [6:0] remain;
	logic last_r;
	byte_t rd_byte;
	logic out_free;
	logic take_cmd;
	logic mem_we;
	byte_t mem_wdata;

	assign out_free = !byte_valid_o || ready_i;	// output slot empties this cycle
	assign take_cmd = (state == S_IDLE) && !cmd_empty_i && out_free;
	assign cmd_rd_o = take_cmd;

	// every emitted byte also lands in the window at wr_ptr
	assign mem_we = (take_cmd && cmd_i.kind == CMD_LIT) || (state == S_WRITE && out_free);
	assign mem_wdata = (state == S_WRITE) ? rd_byte : cmd_i.lit;

	always_ff @(posedge clk) begin
		if (mem_we) begin
			hist_mem[wr_ptr] <= mem_wdata;
			byte_o <= mem_wdata;
		end
		if (state == S_READ)
			rd_byte <= hist_mem[wr_ptr - off_r];	// earlier writes already settled
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state <= S_IDLE;
			wr_ptr <= '0;
			byte_valid_o <= 1'b0;
			byte_last_o <= 1'b0;
		end else if (start_i) begin
			state <= S_IDLE;
			wr_ptr <= '0;
		end else begin
			if (mem_we) begin
				byte_valid_o <= 1'b1;
				wr_ptr <= wr_ptr + 1'b1;	// wraps at the window size
				if (state == S_WRITE)
					byte_last_o <= last_r && (remain == 7'd1);
				else
					byte_last_o <= cmd_i.last_cmd;
			end else if (ready_i) begin
				byte_valid_o <= 1'b0;
				byte_last_o <= 1'b0;
			end

			case (state)
				S_IDLE: begin
					if (take_cmd && cmd_i.kind == CMD_COPY) begin
						off_r <= cmd_i.offset;
						remain <= cmd_i.length;
						last_r <= cmd_i.last_cmd;
						state <= S_READ;
					end
				end
				S_READ: state <= S_WRITE;
				S_WRITE: begin
					if (out_free) begin
						remain <= remain - 7'd1;
						state <= (remain == 7'd1) ? S_IDLE : S_READ;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// ==== output_packer.sv ====
//----------------------------------------------------------------------
// output packer
// gathers engine bytes into bus words with lane valids and last flag
//----------------------------------------------------------------------
`timescale 1ns/1ns
`include "decomp_settings.svh"

module output_packer import decomp_pkg::*; (
	input  logic                     clk,
	input  logic                     rst_i,
	input  logic                     start_i,
	input  byte_t                    byte_i,
	input  logic                     byte_valid_i,
	input  logic                     byte_last_i,
	output logic                     ready_o,
	input  logic [`DECOMP_DLEN_W-1:0] dlen_i,
	output word_t                    data_o,
	output bvalid_t                  byte_valid_o,
	output logic                     last_o,
	output logic                     valid_o,
	input  logic                     wr_ready_i,
	output logic                     done_o
);
	localparam int LANES = $bits(bvalid_t);
	localparam int LANE_W = $clog2(LANES);

	logic [LANE_W-1:0] lane;
	logic [`DECOMP_DLEN_W-1:0] dlen_r;
	logic [`DECOMP_DLEN_W-1:0] out_cnt;
	logic [`DECOMP_DLEN_W-1:0] next_cnt;
	word_t acc;
	word_t next_word;
	bvalid_t next_bv;
	logic ended;	// extra bytes dropped once the file is closed
	logic take;
	logic close;
	logic reach_len;
	logic out_free;

	assign out_free = !valid_o || wr_ready_i;
	assign ready_o = out_free;
	assign take = byte_valid_i && out_free && !ended;
	assign next_cnt = out_cnt + 1'b1;
	assign reach_len = (next_cnt == dlen_r);
	assign close = take && (lane == LANE_W'(LANES - 1) || byte_last_i || reach_len);

	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			if (i < int'(lane)) begin
				next_word[i*8 +: 8] = acc[i*8 +: 8];
				next_bv[i] = 1'b1;
			end else if (i == int'(lane)) begin
				next_word[i*8 +: 8] = byte_i;	// incoming byte
				next_bv[i] = 1'b1;
			end else begin
				next_word[i*8 +: 8] = '0;
				next_bv[i] = 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			acc <= next_word;
		if (close) begin
			data_o <= next_word;
			byte_valid_o <= next_bv;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			lane <= '0;
			dlen_r <= '0;
			out_cnt <= '0;
			ended <= 1'b0;
			valid_o <= 1'b0;
			last_o <= 1'b0;
			done_o <= 1'b0;
		end else begin
			done_o <= valid_o && wr_ready_i && last_o;
			if (start_i) begin
				lane <= '0;
				out_cnt <= '0;
				dlen_r <= dlen_i;
				ended <= 1'b0;
			end else if (take) begin
				out_cnt <= next_cnt;
				lane <= close ? '0 : lane + 1'b1;
				if (byte_last_i || reach_len)
					ended <= 1'b1;
			end

			if (close) begin
				valid_o <= 1'b1;
				last_o <= byte_last_i || reach_len;
			end else if (wr_ready_i) begin
				valid_o <= 1'b0;
				last_o <= 1'b0;
			end
		end
	end

endmodule

// ==== decompressor.sv ====
//----------------------------------------------------------------------
// decompressor top level
// input FIFO, token parser, command FIFO, history engine, packer
//----------------------------------------------------------------------
`timescale 1ns/1ns
`include "decomp_settings.svh"

module decompressor import decomp_pkg::*; (
	input  logic                     clk,
	input  logic                     rst_i,
	input  logic                     start_i,
	input  word_t                    data_i,
	input  logic                     valid_i,
	input  logic [`DECOMP_CLEN_W-1:0] compression_length_i,
	input  logic [`DECOMP_DLEN_W-1:0] decompression_length_i,
	input  logic                     wr_ready_i,
	output logic                     data_fifo_almostfull_o,
	output logic                     done_o,
	output logic                     last_o,
	output word_t                    data_o,
	output bvalid_t                  byte_valid_o,
	output logic                     valid_o
);
	word_t in_word;
	logic in_empty;
	logic in_rd;

	cmd_t cmd_din;
	cmd_t cmd_dout;
	logic cmd_wr;
	logic cmd_rd;
	logic cmd_empty;
	logic cmd_afull;

	byte_t eng_byte;
	logic eng_valid;
	logic eng_last;
	logic pk_ready;

	// almost-full doubles as the ready back to the source
	sync_fifo #(
		.payload_t(word_t),
		.DEPTH(`DECOMP_IN_FIFO_DEPTH)
	) u_in_fifo (
		.clk(clk),
		.rst_i(rst_i),
		.wr_en_i(valid_i & ~data_fifo_almostfull_o),
		.din_i(data_i),
		.rd_en_i(in_rd),
		.dout_o(in_word),
		.empty_o(in_empty),
		.almost_full_o(data_fifo_almostfull_o)
	);

	token_parser u_parser (
		.clk(clk),
		.rst_i(rst_i),
		.start_i(start_i),
		.clen_i(compression_length_i),
		.word_i(in_word),
		.empty_i(in_empty),
		.rd_en_o(in_rd),
		.cmd_o(cmd_din),
		.cmd_wr_o(cmd_wr),
		.cmd_full_i(cmd_afull)
	);

	sync_fifo #(
		.payload_t(cmd_t),
		.DEPTH(`DECOMP_CMD_FIFO_DEPTH)
	) u_cmd_fifo (
		.clk(clk),
		.rst_i(rst_i),
		.wr_en_i(cmd_wr),
		.din_i(cmd_din),
		.rd_en_i(cmd_rd),
		.dout_o(cmd_dout),
		.empty_o(cmd_empty),
		.almost_full_o(cmd_afull)
	);

	history_engine u_engine (
		.clk(clk),
		.rst_i(rst_i),
		.start_i(start_i),
		.cmd_i(cmd_dout),
		.cmd_empty_i(cmd_empty),
		.cmd_rd_o(cmd_rd),
		.byte_o(eng_byte),
		.byte_valid_o(eng_valid),
		.byte_last_o(eng_last),
		.ready_i(pk_ready)
	);

	output_packer u_packer (
		.clk(clk),
		.rst_i(rst_i),
		.start_i(start_i),
		.byte_i(eng_byte),
		.byte_valid_i(eng_valid),
		.byte_last_i(eng_last),
		.ready_o(pk_ready),
		.dlen_i(decompression_length_i),
		.data_o(data_o),
		.byte_valid_o(byte_valid_o),
		.last_o(last_o),
		.valid_o(valid_o),
		.wr_ready_i(wr_ready_i),
		.done_o(done_o)
	);

endmodule

// ==== tb_decompressor.sv ====
//----------------------------------------------------------------------
// decompressor testbench
// directed token files checked against a software decode model
//----------------------------------------------------------------------
`timescale 1ns/1ns
`include "decomp_settings.svh"

module tb_decompressor import decomp_pkg::*; ();
	localparam int LANES = `DECOMP_WORD_BYTES;
	localparam int MARGIN = 2000;	// cycles on top of the byte budget

	logic clk;
	logic rst_i;
	logic start_i;
	word_t data_i;
	logic valid_i;
	logic [`DECOMP_CLEN_W-1:0] compression_length_i;
	logic [`DECOMP_DLEN_W-1:0] decompression_length_i;
	logic wr_ready_i;
	logic data_fifo_almostfull_o;
	logic done_o;
	logic last_o;
	word_t data_o;
	bvalid_t byte_valid_o;
	logic valid_o;

	byte_t comp[$];	// token stream of the current file
	byte_t exp_bytes[$];
	int out_len;	// bytes produced so far while building
	int err_cnt = 0;
	int tests_pass = 0;
	int tests_fail = 0;
	int budget = 0;
	int words_seen;
	bvalid_t last_bv;
	logic af_seen;

	decompressor u_dut (
		.clk(clk),
		.rst_i(rst_i),
		.start_i(start_i),
		.data_i(data_i),
		.valid_i(valid_i),
		.compression_length_i(compression_length_i),
		.decompression_length_i(decompression_length_i),
		.wr_ready_i(wr_ready_i),
		.data_fifo_almostfull_o(data_fifo_almostfull_o),
		.done_o(done_o),
		.last_o(last_o),
		.data_o(data_o),
		.byte_valid_o(byte_valid_o),
		.valid_o(valid_o)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	function automatic void new_file();
		comp.delete();
		out_len = 0;
	endfunction

	function automatic void put_literal(input int len);
		comp.push_back(byte_t'((len - 1) << 2));	// tag 00
		repeat (len) comp.push_back(byte_t'($urandom));
		out_len += len;
	endfunction

	function automatic void put_copy1(input int len, input int off);
		logic [2:0] lcode;
		lcode = 3'(len - 4);
		comp.push_back({off[10:8], lcode, 2'b01});
		comp.push_back(off[7:0]);
		out_len += len;
	endfunction

	function automatic void put_copy2(input int len, input int off);
		logic [5:0] lcode;
		lcode = 6'(len - 1);
		comp.push_back({lcode, 2'b10});
		comp.push_back(off[7:0]);	// low byte first
		comp.push_back(off[15:8]);
		out_len += len;
	endfunction

	// reference decode of comp into exp_bytes
	function automatic void decode_model();
		int p;
		int len;
		int off;
		byte_t tag;
		exp_bytes.delete();
		p = 0;
		while (p < comp.size()) begin
			tag = comp[p];
			p++;
			len = 0;
			off = 0;
			case (tag[1:0])
				2'b00: begin
					len = int'(tag[7:2]) + 1;
					repeat (len) begin
						exp_bytes.push_back(comp[p]);
						p++;
					end
					len = 0;
				end
				2'b01: begin
					len = int'(tag[4:2]) + 4;
					off = int'({tag[7:5], comp[p]});
					p++;
				end
				2'b10: begin
					len = int'(tag[7:2]) + 1;
					off = int'({comp[p + 1], comp[p]});
					p += 2;
				end
				default: p = comp.size();
			endcase
			for (int k = 0; k < len; k++)	// byte by byte so overlaps repeat
				exp_bytes.push_back(exp_bytes[exp_bytes.size() - off]);
		end
	endfunction

	task automatic drive_input(input int gap_pct);
		int nwords;
		int i;
		word_t w;
		nwords = (comp.size() + LANES - 1) / LANES;
		i = 0;
		while (i < nwords) begin
			@(negedge clk);
			for (int l = 0; l < LANES; l++) begin
				if (i * LANES + l < comp.size())
					w[l*8 +: 8] = comp[i * LANES + l];
				else
					w[l*8 +: 8] = byte_t'($urandom);	// padding the parser ignores
			end
			data_i = w;
			valid_i = ($urandom_range(99) >= gap_pct);
			if (data_fifo_almostfull_o)
				af_seen = 1'b1;
			if (valid_i && !data_fifo_almostfull_o)
				i++;
		end
		@(negedge clk);
		valid_i = 1'b0;
	endtask

	task automatic check_word(input int n);
		word_t ew;
		word_t mask;
		bvalid_t ebv;
		int nwords;
		ew = '0;
		mask = '0;
		ebv = '0;
		nwords = (exp_bytes.size() + LANES - 1) / LANES;
		for (int l = 0; l < LANES; l++) begin
			if (n * LANES + l < exp_bytes.size()) begin
				ew[l*8 +: 8] = exp_bytes[n * LANES + l];
				mask[l*8 +: 8] = 8'hff;
				ebv[l] = 1'b1;
			end
		end
		assert (n < nwords) else begin
			$display("word %0d arrived but only %0d words were expected", n, nwords);
			err_cnt++;
		end
		assert ((data_o & mask) == ew) else begin
			$display("FAILED word %0d data_o: got %h expected %h", n, data_o & mask, ew);
			err_cnt++;
		end
		assert (byte_valid_o == ebv) else begin
			$display("FAILED word %0d byte_valid_o: got %h expected %h", n, byte_valid_o, ebv);
			err_cnt++;
		end
		assert (last_o == (n == nwords - 1)) else begin
			$display("FAILED word %0d last_o: got %h expected %h", n, last_o, n == nwords - 1);
			err_cnt++;
		end
	endtask

	task automatic collect_output(input int rdy_pct, input int hold);
		int n;
		int cyc;
		logic held;
		logic got_last;
		word_t hdata;
		bvalid_t hbv;
		logic hlast;
		n = 0;
		cyc = 0;
		held = 1'b0;
		got_last = 1'b0;
		while (!got_last) begin
			@(negedge clk);
			if (held) begin	// word was refused on the last edge
				assert (valid_o && data_o == hdata && byte_valid_o == hbv
					&& last_o == hlast) else begin
					$display("FAILED held data_o: got %h/%h/%h expected %h/%h/%h",
						data_o, byte_valid_o, last_o, hdata, hbv, hlast);
					err_cnt++;
				end
			end
			assert (!done_o) else begin
				$display("FAILED done_o before the last word: got %h expected 0", done_o);
				err_cnt++;
			end
			wr_ready_i = (cyc >= hold) && ($urandom_range(99) < rdy_pct);
			cyc++;
			if (valid_o && wr_ready_i) begin
				check_word(n);
				got_last = last_o;
				last_bv = byte_valid_o;
				n++;
				held = 1'b0;
			end else begin
				held = valid_o;
				hdata = data_o;
				hbv = byte_valid_o;
				hlast = last_o;
			end
		end
		words_seen = n;
		assert (n == (exp_bytes.size() + LANES - 1) / LANES) else begin
			$display("last_o came after %0d words, too early", n);
			err_cnt++;
		end
		@(negedge clk);
		assert (done_o) else begin
			$display("FAILED done_o after the last word: got %h expected 1", done_o);
			err_cnt++;
		end
		@(negedge clk);
		assert (!done_o) else begin
			$display("FAILED done_o one cycle later: got %h expected 0", done_o);
			err_cnt++;
		end
	endtask

	task automatic run_file(input int gap_pct, input int rdy_pct, input int hold);
		decode_model();
		budget += (comp.size() + exp_bytes.size()) * 8 + hold;
		af_seen = 1'b0;
		@(negedge clk);
		compression_length_i = `DECOMP_CLEN_W'(comp.size());
		decompression_length_i = `DECOMP_DLEN_W'(exp_bytes.size());
		start_i = 1'b1;
		@(negedge clk);
		start_i = 1'b0;
		fork
			drive_input(gap_pct);
			collect_output(rdy_pct, hold);
		join
	endtask

	task automatic report_test(input string name, input int err0);
		if (err_cnt == err0) begin
			tests_pass++;
			$display("%s: pass", name);
		end else begin
			tests_fail++;
			$display("%s: %0d errors", name, err_cnt - err0);
		end
	endtask

	task automatic literal_only_test();
		int err0;
		err0 = err_cnt;
		new_file();
		put_literal(23);
		run_file(0, 100, 0);
		assert (words_seen == 6 && last_bv == 4'b0111) else begin
			$display("FAILED literal file shape: words %h last byte_valid_o %h",
				words_seen, last_bv);
			err_cnt++;
		end
		report_test("literal_only", err0);
	endtask

	task automatic plain_copy_test();
		int err0;
		err0 = err_cnt;
		new_file();
		repeat (5) put_literal(60);
		put_copy1(6, 10);
		put_copy2(8, 16);
		put_literal(5);
		put_copy2(12, 20);
		put_copy1(7, 290);	// high offset bits in the tag
		put_copy2(20, 270);
		run_file(0, 100, 0);
		report_test("plain_copy", err0);
	endtask

	task automatic overlap_copy_test();
		int err0;
		err0 = err_cnt;
		new_file();
		put_literal(1);
		put_copy2(20, 1);	// one byte repeated
		put_literal(3);
		put_copy1(9, 3);
		put_copy2(30, 3);	// 3-byte pattern
		put_literal(2);
		run_file(0, 100, 0);
		report_test("overlap_copy", err0);
	endtask

	task automatic random_ready_test();
		int err0;
		int lim;
		err0 = err_cnt;
		new_file();
		put_literal(8);
		repeat (30) begin
			lim = (out_len < 2047) ? out_len : 2047;
			case ($urandom_range(2))
				0: put_literal($urandom_range(12, 1));
				1: put_copy1($urandom_range(11, 4), $urandom_range(lim, 1));
				default: put_copy2($urandom_range(64, 1), $urandom_range(out_len, 1));
			endcase
		end
		run_file(0, 50, 0);
		report_test("random_ready", err0);
	endtask

	task automatic backpressure_test();
		int err0;
		err0 = err_cnt;
		new_file();
		repeat (4) put_literal(48);
		run_file(30, 70, 200);	// output held low for a while
		assert (af_seen) else begin
			$display("data_fifo_almostfull_o never rose while the output was held");
			err_cnt++;
		end
		new_file();
		put_literal(20);
		put_copy2(40, 7);
		put_copy1(10, 15);
		put_literal(9);
		run_file(30, 70, 0);
		report_test("backpressure", err0);
	endtask

	initial begin : watchdog
		int cyc;
		cyc = 0;
		while (cyc <= budget + MARGIN) begin
			@(posedge clk);
			cyc++;
		end
		$display("run timed out after %0d cycles", cyc);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		void'($urandom(32'h60b8fd12));
		rst_i = 1'b1;
		start_i = 1'b0;
		data_i = '0;
		valid_i = 1'b0;
		compression_length_i = '0;
		decompression_length_i = '0;
		wr_ready_i = 1'b0;
		repeat (2) @(negedge clk);
		rst_i = 1'b0;
		assert (!valid_o && !last_o && !done_o && !data_fifo_almostfull_o) else begin
			$display("FAILED after reset valid_o %h last_o %h done_o %h expected 0",
				valid_o, last_o, done_o);
			$display("FAILED after reset data_fifo_almostfull_o %h expected 0",
				data_fifo_almostfull_o);
			err_cnt++;
		end

		literal_only_test();
		plain_copy_test();
		overlap_copy_test();
		random_ready_test();
		backpressure_test();

		$display("tests: %0d passed, %0d failed", tests_pass, tests_fail);
		if (tests_fail == 0 && err_cnt == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+.
decomp_pkg.sv
sync_fifo.sv
token_parser.sv
history_engine.sv
output_packer.sv
decompressor.sv
tb_decompressor.sv

// ==== Makefile ====
# Verilator build and run of the decompressor testbench

VERILATOR ?= verilator
TOP       ?= tb_decompressor
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
